//--- source/page_migrate_pkg.sv
// hot page pusher shared definitions
// port widths, page geometry and the issuer state encodings
package page_migrate_pkg;

    typedef logic [63:0] addr_t;      // byte address on the memory port
    typedef logic [511:0] line_t;     // one data line
    typedef logic [5:0] off_t;        // line offset within a 4 KB page
    typedef logic [11:0] axi_id_t;    // page number sits above the offset

    localparam int LINE_BYTES = 64;   // address stride per line
    localparam int PG_LINES = 64;

    typedef enum logic {
        RD_IDLE,
        RD_ADDR
    } rd_state_e;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA
    } wr_state_e;

endpackage

//--- source/page_slot.sv
`timescale 1ns/1ps
// page slot
// holds one page's source and destination base, its pending flag and
// the count of write responses returned for its 64 lines
module page_slot (
    input  logic                    axi4_mm_clk,
    input  logic                    rst,
    input  logic                    load,
    input  page_migrate_pkg::addr_t src_in,
    input  page_migrate_pkg::addr_t dst_in,
    input  logic                    claim,
    input  logic                    bresp_hit,
    input  logic                    clear,
    output page_migrate_pkg::addr_t src_base,
    output page_migrate_pkg::addr_t dst_base,
    output logic                    pending,
    output logic                    used,
    output logic                    ready
);
    import page_migrate_pkg::*;

    off_t resp_cnt;
    logic resp_seen;    // at least one response since load

    assign used = (src_base != '0) && (dst_base != '0);
    // all 64 responses back once the counter wraps to zero
    assign ready = !used || (resp_seen && resp_cnt == '0);

    always_ff @(posedge axi4_mm_clk) begin
        if (rst) begin
            src_base <= '0;
            dst_base <= '0;
            pending <= 1'b0;
            resp_cnt <= '0;
            resp_seen <= 1'b0;
        end else if (load) begin
            src_base <= src_in;
            dst_base <= dst_in;
            pending <= (src_in != '0) && (dst_in != '0);   // zero base means skip
            resp_cnt <= '0;
            resp_seen <= 1'b0;
        end else if (clear) begin
            src_base <= '0;
            dst_base <= '0;
            pending <= 1'b0;
            resp_cnt <= '0;
            resp_seen <= 1'b0;
        end else begin
            if (claim) begin
                pending <= 1'b0;
            end
            if (bresp_hit) begin
                resp_cnt <= resp_cnt + 1'b1;
                resp_seen <= 1'b1;
            end
        end
    end

    // the read issuer may only start a page that is still waiting
    assert property (@(posedge axi4_mm_clk) disable iff (rst) claim |-> pending)
        else $error("claim of a slot that is not pending");

endmodule

//--- source/read_issuer.sv
`timescale 1ns/1ps
// read issuer
// claims the highest pending page, walks its 64 line reads on the AR
// channel and tags returning read data into the line FIFO
module read_issuer #(
    parameter int MIG_GRP_SIZE = 16,
    localparam int PG_W = $clog2(MIG_GRP_SIZE),
    localparam int ENTRY_W = PG_W + $bits(page_migrate_pkg::off_t)
                             + $bits(page_migrate_pkg::line_t)
) (
    input  logic                      axi4_mm_clk,
    input  logic                      rst,
    input  logic [MIG_GRP_SIZE-1:0]   pending,
    input  page_migrate_pkg::addr_t   src_base [MIG_GRP_SIZE],
    input  logic [5:0]                csr_aruser,
    input  logic                      hppb_arready,
    input  page_migrate_pkg::axi_id_t hppb_rid,
    input  page_migrate_pkg::line_t   hppb_rdata,
    input  logic                      hppb_rvalid,
    input  logic                      hppb_rlast,
    input  logic                      fifo_full,
    output logic [MIG_GRP_SIZE-1:0]   claim,
    output logic                      hppb_arvalid,
    output page_migrate_pkg::axi_id_t hppb_arid,
    output page_migrate_pkg::addr_t   hppb_araddr,
    output logic [5:0]                hppb_aruser,
    output logic                      hppb_rready,
    output logic                      fifo_push,
    output logic [ENTRY_W-1:0]        fifo_wdata
);
    import page_migrate_pkg::*;

    rd_state_e state;
    logic [PG_W-1:0] pg;
    logic [PG_W-1:0] sel;
    off_t off;
    logic ar_hold;      // request shown last cycle and not yet taken
    logic ar_fire;
    logic last_line;

    // later hits overwrite, so the highest pending page wins
    always_comb begin
        sel = '0;
        for (int i = 0; i < MIG_GRP_SIZE; i++) begin
            if (pending[i]) begin
                sel = PG_W'(i);
            end
        end
    end

    assign claim = (state == RD_IDLE && pending != '0) ? (MIG_GRP_SIZE'(1) << sel) : '0;

    // a new request waits for FIFO room, a shown one is held until taken
    assign hppb_arvalid = (state == RD_ADDR) && (ar_hold || !fifo_full);
    assign ar_fire = hppb_arvalid && hppb_arready;
    assign last_line = (off == off_t'(PG_LINES - 1));
    assign hppb_arid = axi_id_t'({pg, off});
    assign hppb_araddr = src_base[pg] + addr_t'(off) * LINE_BYTES;
    assign hppb_aruser = {1'b1, csr_aruser[4:0]};

    always_ff @(posedge axi4_mm_clk) begin
        if (rst) begin
            state <= RD_IDLE;
            pg <= '0;
            off <= '0;
            ar_hold <= 1'b0;
        end else begin
            ar_hold <= hppb_arvalid && !hppb_arready;
            case (state)
                RD_IDLE: begin
                    if (pending != '0) begin
                        state <= RD_ADDR;
                        pg <= sel;
                        off <= '0;
                    end
                end
                RD_ADDR: begin
                    if (ar_fire) begin
                        off <= off + 1'b1;    // wraps to 0 after the last line
                        if (last_line) begin
                            state <= RD_IDLE;
                        end
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // read data path, rid already carries {page, offset}
    assign hppb_rready = !fifo_full;
    assign fifo_push = hppb_rvalid && hppb_rready && hppb_rlast;
    assign fifo_wdata = {hppb_rid[PG_W+$bits(off_t)-1:0], hppb_rdata};

    assert property (@(posedge axi4_mm_clk) disable iff (rst)
        hppb_arvalid && !hppb_arready |=> hppb_arvalid && $stable(hppb_araddr))
        else $error("read request changed before it was accepted");

endmodule

//--- source/line_fifo.sv
`timescale 1ns/1ps
// line FIFO
// first-word-fall-through buffer of tagged lines between the read and
// write issuers, head entry is visible without a pop
module line_fifo #(
    parameter int MIG_GRP_SIZE = 16,
    parameter int FIFO_DEPTH = 16,
    localparam int ENTRY_W = $clog2(MIG_GRP_SIZE) + $bits(page_migrate_pkg::off_t)
                             + $bits(page_migrate_pkg::line_t),
    localparam int AW = $clog2(FIFO_DEPTH)
) (
    input  logic               axi4_mm_clk,
    input  logic               rst,
    input  logic               push,
    input  logic [ENTRY_W-1:0] wdata,
    input  logic               pop,
    output logic [ENTRY_W-1:0] rdata,
    output logic               full,
    output logic               empty
);

    logic [ENTRY_W-1:0] mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0] count;

    assign rdata = mem[rd_ptr];
    assign full = (count == (AW+1)'(FIFO_DEPTH));
    assign empty = (count == '0);

    always_ff @(posedge axi4_mm_clk) begin
        if (push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge axi4_mm_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (AW+1)'(push) - (AW+1)'(pop);
        end
    end

    assert property (@(posedge axi4_mm_clk) disable iff (rst) pop |-> !empty)
        else $error("pop from an empty line FIFO");

endmodule

//--- source/write_issuer.sv
`timescale 1ns/1ps
// write issuer
// takes tagged lines off the FIFO head and issues one write address and
// one data beat per line, data may trail the address
module write_issuer #(
    parameter int MIG_GRP_SIZE = 16,
    localparam int PG_W = $clog2(MIG_GRP_SIZE),
    localparam int ENTRY_W = PG_W + $bits(page_migrate_pkg::off_t)
                             + $bits(page_migrate_pkg::line_t)
) (
    input  logic                                axi4_mm_clk,
    input  logic                                rst,
    input  logic [ENTRY_W-1:0]                  fifo_rdata,
    input  logic                                fifo_empty,
    input  page_migrate_pkg::addr_t             dst_base [MIG_GRP_SIZE],
    input  logic [5:0]                          csr_awuser,
    input  logic                                hppb_awready,
    input  logic                                hppb_wready,
    output logic                                fifo_pop,
    output logic                                hppb_awvalid,
    output page_migrate_pkg::axi_id_t           hppb_awid,
    output page_migrate_pkg::addr_t             hppb_awaddr,
    output logic [5:0]                          hppb_awuser,
    output page_migrate_pkg::line_t             hppb_wdata,
    output logic [page_migrate_pkg::LINE_BYTES-1:0] hppb_wstrb,
    output logic                                hppb_wlast,
    output logic                                hppb_wvalid,
    output logic                                hppb_bready
);
    import page_migrate_pkg::*;

    wr_state_e state;
    line_t data_q;      // line whose address went out ahead of its data
    logic [PG_W-1:0] head_pg;
    off_t head_off;
    line_t head_data;

    assign {head_pg, head_off, head_data} = fifo_rdata;

    // head stays put until popped, so the address is stable while waiting
    assign hppb_awvalid = (state == WR_ADDR) && !fifo_empty;
    assign fifo_pop = hppb_awvalid && hppb_awready;
    assign hppb_awid = axi_id_t'({head_pg, head_off});
    assign hppb_awaddr = dst_base[head_pg] + addr_t'(head_off) * LINE_BYTES;
    assign hppb_awuser = csr_awuser;

    assign hppb_wvalid = fifo_pop || (state == WR_DATA);
    assign hppb_wdata = (state == WR_DATA) ? data_q : head_data;
    assign hppb_wstrb = '1;
    assign hppb_wlast = 1'b1;     // single beat per line
    assign hppb_bready = 1'b1;

    always_ff @(posedge axi4_mm_clk) begin
        if (fifo_pop) begin
            data_q <= head_data;
        end
    end

    always_ff @(posedge axi4_mm_clk) begin
        if (rst) begin
            state <= WR_IDLE;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (!fifo_empty) begin
                        state <= WR_ADDR;
                    end
                end
                WR_ADDR: begin
                    if (fifo_pop && !hppb_wready) begin
                        state <= WR_DATA;    // data beat still owed
                    end else if (fifo_empty) begin
                        state <= WR_IDLE;
                    end
                end
                WR_DATA: begin
                    if (hppb_wready) begin
                        state <= fifo_empty ? WR_IDLE : WR_ADDR;
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

endmodule

//--- source/batch_tracker.sv
`timescale 1ns/1ps
// batch tracker
// raises the done pulse once every used slot has all its write responses,
// counts finished batches and reports whether any source is loaded
module batch_tracker #(
    parameter int MIG_GRP_SIZE = 16
) (
    input  logic                    axi4_mm_clk,
    input  logic                    rst,
    input  logic [MIG_GRP_SIZE-1:0] slot_ready,
    input  logic [MIG_GRP_SIZE-1:0] slot_used,
    input  logic [MIG_GRP_SIZE-1:0] src_nonzero,
    output logic                    batch_done,
    output logic [63:0]             mig_done_cnt,
    output logic                    atleast_one_valid_src
);

    assign batch_done = (slot_used != '0) && (&slot_ready);
    assign atleast_one_valid_src = |src_nonzero;

    always_ff @(posedge axi4_mm_clk) begin
        if (rst) begin
            mig_done_cnt <= '0;
        end else if (batch_done) begin
            mig_done_cnt <= mig_done_cnt + 1'b1;
        end
    end

    // done clears every slot, so a batch is never counted twice
    assert property (@(posedge axi4_mm_clk) disable iff (rst) batch_done |=> !batch_done)
        else $error("batch done held for more than one cycle");

endmodule

//--- source/hot_page_push.sv
`timescale 1ns/1ps
// hot page pusher top level
// copies a group of 4 KB pages from source to destination addresses over
// the memory port, one page slot per page, reads feed a line FIFO that
// drains into writes, and each completed group bumps the done counter
module hot_page_push #(
    parameter int MIG_GRP_SIZE = 16,    // 2 to 32 pages
    parameter int FIFO_DEPTH = 16       // power of two
) (
    input  logic                      axi4_mm_clk,
    input  logic                      rst,
    input  logic                      new_addr_available,
    input  page_migrate_pkg::addr_t   src_addr [MIG_GRP_SIZE],
    input  page_migrate_pkg::addr_t   dst_addr [MIG_GRP_SIZE],
    input  logic [5:0]                csr_aruser,
    input  logic [5:0]                csr_awuser,
    output logic [63:0]               mig_done_cnt,
    output logic                      atleast_one_valid_src,
    // read address and data
    output page_migrate_pkg::axi_id_t hppb_arid,
    output page_migrate_pkg::addr_t   hppb_araddr,
    output logic [5:0]                hppb_aruser,
    output logic                      hppb_arvalid,
    input  logic                      hppb_arready,
    input  page_migrate_pkg::axi_id_t hppb_rid,
    input  page_migrate_pkg::line_t   hppb_rdata,
    input  logic                      hppb_rlast,
    input  logic                      hppb_rvalid,
    output logic                      hppb_rready,
    // write address, data and response
    output page_migrate_pkg::axi_id_t hppb_awid,
    output page_migrate_pkg::addr_t   hppb_awaddr,
    output logic [5:0]                hppb_awuser,
    output logic                      hppb_awvalid,
    input  logic                      hppb_awready,
    output page_migrate_pkg::line_t   hppb_wdata,
    output logic [63:0]               hppb_wstrb,
    output logic                      hppb_wlast,
    output logic                      hppb_wvalid,
    input  logic                      hppb_wready,
    input  page_migrate_pkg::axi_id_t hppb_bid,
    input  logic                      hppb_bvalid,
    output logic                      hppb_bready
);
    import page_migrate_pkg::*;

    localparam int PG_W = $clog2(MIG_GRP_SIZE);
    localparam int ENTRY_W = PG_W + $bits(off_t) + $bits(line_t);

    addr_t src_base [MIG_GRP_SIZE];
    addr_t dst_base [MIG_GRP_SIZE];
    logic [MIG_GRP_SIZE-1:0] slot_pending;
    logic [MIG_GRP_SIZE-1:0] slot_claim;
    logic [MIG_GRP_SIZE-1:0] slot_used;
    logic [MIG_GRP_SIZE-1:0] slot_ready;
    logic [MIG_GRP_SIZE-1:0] src_nonzero;
    logic [MIG_GRP_SIZE-1:0] bresp_hit;
    logic batch_done;
    logic fifo_push;
    logic fifo_pop;
    logic fifo_full;
    logic fifo_empty;
    logic [ENTRY_W-1:0] fifo_wdata;
    logic [ENTRY_W-1:0] fifo_rdata;
    logic [PG_W-1:0] bid_page;

    assign bid_page = hppb_bid[PG_W+$bits(off_t)-1:$bits(off_t)];   // page bits of the response id

    for (genvar i = 0; i < MIG_GRP_SIZE; i++) begin : g_slot
        assign bresp_hit[i] = hppb_bvalid && hppb_bready && (bid_page == PG_W'(i));
        assign src_nonzero[i] = (src_base[i] != '0);

        page_slot page_slot_inst (
            .axi4_mm_clk (axi4_mm_clk),
            .rst         (rst),
            .load        (new_addr_available),
            .src_in      (src_addr[i]),
            .dst_in      (dst_addr[i]),
            .claim       (slot_claim[i]),
            .bresp_hit   (bresp_hit[i]),
            .clear       (batch_done),
            .src_base    (src_base[i]),
            .dst_base    (dst_base[i]),
            .pending     (slot_pending[i]),
            .used        (slot_used[i]),
            .ready       (slot_ready[i])
        );
    end

    read_issuer #(.MIG_GRP_SIZE(MIG_GRP_SIZE)) read_issuer_inst (
        .axi4_mm_clk  (axi4_mm_clk),
        .rst          (rst),
        .pending      (slot_pending),
        .src_base     (src_base),
        .csr_aruser   (csr_aruser),
        .hppb_arready (hppb_arready),
        .hppb_rid     (hppb_rid),
        .hppb_rdata   (hppb_rdata),
        .hppb_rvalid  (hppb_rvalid),
        .hppb_rlast   (hppb_rlast),
        .fifo_full    (fifo_full),
        .claim        (slot_claim),
        .hppb_arvalid (hppb_arvalid),
        .hppb_arid    (hppb_arid),
        .hppb_araddr  (hppb_araddr),
        .hppb_aruser  (hppb_aruser),
        .hppb_rready  (hppb_rready),
        .fifo_push    (fifo_push),
        .fifo_wdata   (fifo_wdata)
    );

    line_fifo #(.MIG_GRP_SIZE(MIG_GRP_SIZE), .FIFO_DEPTH(FIFO_DEPTH)) line_fifo_inst (
        .axi4_mm_clk (axi4_mm_clk),
        .rst         (rst),
        .push        (fifo_push),
        .wdata       (fifo_wdata),
        .pop         (fifo_pop),
        .rdata       (fifo_rdata),
        .full        (fifo_full),
        .empty       (fifo_empty)
    );

    write_issuer #(.MIG_GRP_SIZE(MIG_GRP_SIZE)) write_issuer_inst (
        .axi4_mm_clk  (axi4_mm_clk),
        .rst          (rst),
        .fifo_rdata   (fifo_rdata),
        .fifo_empty   (fifo_empty),
        .dst_base     (dst_base),
        .csr_awuser   (csr_awuser),
        .hppb_awready (hppb_awready),
        .hppb_wready  (hppb_wready),
        .fifo_pop     (fifo_pop),
        .hppb_awvalid (hppb_awvalid),
        .hppb_awid    (hppb_awid),
        .hppb_awaddr  (hppb_awaddr),
        .hppb_awuser  (hppb_awuser),
        .hppb_wdata   (hppb_wdata),
        .hppb_wstrb   (hppb_wstrb),
        .hppb_wlast   (hppb_wlast),
        .hppb_wvalid  (hppb_wvalid),
        .hppb_bready  (hppb_bready)
    );

    batch_tracker #(.MIG_GRP_SIZE(MIG_GRP_SIZE)) batch_tracker_inst (
        .axi4_mm_clk           (axi4_mm_clk),
        .rst                   (rst),
        .slot_ready            (slot_ready),
        .slot_used             (slot_used),
        .src_nonzero           (src_nonzero),
        .batch_done            (batch_done),
        .mig_done_cnt          (mig_done_cnt),
        .atleast_one_valid_src (atleast_one_valid_src)
    );

endmodule

//--- test/tb_hot_page_push.sv
`timescale 1ns/1ps
// testbench for the hot page pusher
// a memory model with random ready stalls answers each read with its
// address replicated over the line and acknowledges each write in order
// scoreboard assertions check requests, data beats and the batch count
module tb_hot_page_push;
    import page_migrate_pkg::*;

    localparam int GRP = 4;
    localparam int DEPTH = 8;
    localparam int PG_W = $clog2(GRP);
    localparam int NUM_BATCHES = 4;
    localparam int TIMEOUT_CYCLES = NUM_BATCHES * GRP * PG_LINES * 20 + 200;

    logic axi4_mm_clk;
    logic rst;
    logic new_addr_available;
    addr_t src_addr [GRP];
    addr_t dst_addr [GRP];
    logic [5:0] csr_aruser;
    logic [5:0] csr_awuser;
    logic [63:0] mig_done_cnt;
    logic atleast_one_valid_src;
    axi_id_t hppb_arid;
    addr_t hppb_araddr;
    logic [5:0] hppb_aruser;
    logic hppb_arvalid;
    logic hppb_arready = 1'b0;
    axi_id_t hppb_rid = '0;
    line_t hppb_rdata = '0;
    logic hppb_rlast = 1'b1;    // every read is a single beat
    logic hppb_rvalid = 1'b0;
    logic hppb_rready;
    axi_id_t hppb_awid;
    addr_t hppb_awaddr;
    logic [5:0] hppb_awuser;
    logic hppb_awvalid;
    logic hppb_awready = 1'b0;
    line_t hppb_wdata;
    logic [63:0] hppb_wstrb;
    logic hppb_wlast;
    logic hppb_wvalid;
    logic hppb_wready = 1'b0;
    axi_id_t hppb_bid = '0;
    logic hppb_bvalid = 1'b0;
    logic hppb_bready;

    // bases loaded per batch, and which lines were already seen
    addr_t src_tab [NUM_BATCHES][GRP];
    addr_t dst_tab [NUM_BATCHES][GRP];
    logic rd_seen [NUM_BATCHES][GRP][PG_LINES];
    logic wr_seen [NUM_BATCHES][GRP][PG_LINES];
    int cur_batch;
    int exp_lines;              // lines expected over all batches so far
    int rd_count = 0;
    int wr_count = 0;
    int b_count = 0;
    logic [63:0] last_cnt = '0;

    // memory model state
    logic [31:0] rng = 32'h33fa_4d07;
    logic [1:0] r_wait = '0;
    logic [75:0] rd_q [$];      // {arid, araddr} in acceptance order
    logic [75:0] rd_entry;
    axi_id_t aw_q [$];
    axi_id_t b_q [$];
    axi_id_t w_id;
    logic [PG_W-1:0] ar_pg;
    logic [PG_W-1:0] w_pg;
    off_t ar_off;
    off_t w_off;
    addr_t ar_exp;
    addr_t aw_exp;
    addr_t w_src;

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    hot_page_push #(.MIG_GRP_SIZE(GRP), .FIFO_DEPTH(DEPTH)) hot_page_push_inst (
        .axi4_mm_clk (axi4_mm_clk), .rst (rst),
        .new_addr_available (new_addr_available),
        .src_addr (src_addr), .dst_addr (dst_addr),
        .csr_aruser (csr_aruser), .csr_awuser (csr_awuser),
        .mig_done_cnt (mig_done_cnt), .atleast_one_valid_src (atleast_one_valid_src),
        .hppb_arid (hppb_arid), .hppb_araddr (hppb_araddr), .hppb_aruser (hppb_aruser),
        .hppb_arvalid (hppb_arvalid), .hppb_arready (hppb_arready),
        .hppb_rid (hppb_rid), .hppb_rdata (hppb_rdata), .hppb_rlast (hppb_rlast),
        .hppb_rvalid (hppb_rvalid), .hppb_rready (hppb_rready),
        .hppb_awid (hppb_awid), .hppb_awaddr (hppb_awaddr), .hppb_awuser (hppb_awuser),
        .hppb_awvalid (hppb_awvalid), .hppb_awready (hppb_awready),
        .hppb_wdata (hppb_wdata), .hppb_wstrb (hppb_wstrb), .hppb_wlast (hppb_wlast),
        .hppb_wvalid (hppb_wvalid), .hppb_wready (hppb_wready),
        .hppb_bid (hppb_bid), .hppb_bvalid (hppb_bvalid), .hppb_bready (hppb_bready)
    );

    initial begin
        axi4_mm_clk = 1'b0;
        forever #4 axi4_mm_clk = ~axi4_mm_clk;
    end

    // random stalls on the three ready inputs, roughly one cycle in four
    always @(posedge axi4_mm_clk) begin
        rng <= xorshift32(rng);
        if (rst) begin
            hppb_arready <= 1'b0;
            hppb_awready <= 1'b0;
            hppb_wready <= 1'b0;
        end else begin
            hppb_arready <= (rng[1:0] != 2'b00);
            hppb_awready <= (rng[3:2] != 2'b00);
            hppb_wready <= (rng[5:4] != 2'b00);
        end
    end

    // read side of the memory model
    always @(posedge axi4_mm_clk) begin
        if (rst) begin
            hppb_rvalid <= 1'b0;
            r_wait <= '0;
            for (int b = 0; b < NUM_BATCHES; b++) begin
                for (int p = 0; p < GRP; p++) begin
                    for (int k = 0; k < PG_LINES; k++) begin
                        rd_seen[b][p][k] <= 1'b0;
                    end
                end
            end
        end else begin
            if (hppb_arvalid && hppb_arready) begin
                ar_pg = hppb_arid[PG_W+5:6];
                ar_off = hppb_arid[5:0];
                ar_exp = src_tab[cur_batch][ar_pg] + 64'(ar_off) * 64'(LINE_BYTES);
                assert (hppb_arid < axi_id_t'(GRP * PG_LINES) && src_tab[cur_batch][ar_pg] != '0)
                    else stop_with_failure($sformatf("[FAIL] %0t: read id %h names no loaded page",
                                                     $time, hppb_arid));
                assert (hppb_araddr == ar_exp)
                    else stop_with_failure($sformatf("[FAIL] %0t: read address %h, expected %h",
                                                     $time, hppb_araddr, ar_exp));
                assert (hppb_aruser == (csr_aruser | 6'h20))
                    else stop_with_failure($sformatf("[FAIL] %0t: aruser %h", $time, hppb_aruser));
                assert (!rd_seen[cur_batch][ar_pg][ar_off])
                    else stop_with_failure($sformatf("[FAIL] %0t: read id %h requested twice",
                                                     $time, hppb_arid));
                rd_seen[cur_batch][ar_pg][ar_off] <= 1'b1;
                rd_count <= rd_count + 1;
                rd_q.push_back({hppb_arid, hppb_araddr});
            end
            if (!hppb_rvalid || hppb_rready) begin
                if (rd_q.size() != 0 && r_wait == 2'd0) begin
                    rd_entry = rd_q.pop_front();
                    hppb_rvalid <= 1'b1;
                    hppb_rid <= rd_entry[75:64];
                    hppb_rdata <= {8{rd_entry[63:0]}};    // line holds its own address
                    r_wait <= rng[9:8];
                end else begin
                    hppb_rvalid <= 1'b0;
                    if (r_wait != 2'd0) begin
                        r_wait <= r_wait - 2'd1;
                    end
                end
            end
        end
    end

    // write side, responses follow completed writes in order
    always @(posedge axi4_mm_clk) begin
        if (rst) begin
            hppb_bvalid <= 1'b0;
            for (int b = 0; b < NUM_BATCHES; b++) begin
                for (int p = 0; p < GRP; p++) begin
                    for (int k = 0; k < PG_LINES; k++) begin
                        wr_seen[b][p][k] <= 1'b0;
                    end
                end
            end
        end else begin
            if (hppb_awvalid && hppb_awready) begin
                w_pg = hppb_awid[PG_W+5:6];
                w_off = hppb_awid[5:0];
                aw_exp = dst_tab[cur_batch][w_pg] + 64'(w_off) * 64'(LINE_BYTES);
                assert (hppb_awid < axi_id_t'(GRP * PG_LINES) && src_tab[cur_batch][w_pg] != '0)
                    else stop_with_failure($sformatf("[FAIL] %0t: write id %h names no used page",
                                                     $time, hppb_awid));
                assert (hppb_awaddr == aw_exp && hppb_awuser == csr_awuser)
                    else stop_with_failure($sformatf("[FAIL] %0t: write address %h, expected %h",
                                                     $time, hppb_awaddr, aw_exp));
                aw_q.push_back(hppb_awid);
            end
            if (hppb_wvalid && hppb_wready) begin
                assert (aw_q.size() != 0)
                    else stop_with_failure("a write data beat arrived before its address");
                w_id = aw_q.pop_front();
                w_pg = w_id[PG_W+5:6];
                w_off = w_id[5:0];
                w_src = src_tab[cur_batch][w_pg] + 64'(w_off) * 64'(LINE_BYTES);
                assert (hppb_wdata == {8{w_src}})
                    else stop_with_failure($sformatf("[FAIL] %0t: write data for id %h is wrong",
                                                     $time, w_id));
                assert (hppb_wstrb == '1 && hppb_wlast)
                    else stop_with_failure($sformatf("[FAIL] %0t: wstrb %h wlast %b",
                                                     $time, hppb_wstrb, hppb_wlast));
                assert (!wr_seen[cur_batch][w_pg][w_off])
                    else stop_with_failure($sformatf("[FAIL] %0t: line %h written twice",
                                                     $time, w_id));
                wr_seen[cur_batch][w_pg][w_off] <= 1'b1;
                wr_count <= wr_count + 1;
                b_q.push_back(w_id);
            end
            if (hppb_bvalid && hppb_bready) begin
                b_count <= b_count + 1;
            end
            // a response is held until bready takes it
            if (!hppb_bvalid || hppb_bready) begin
                if (b_q.size() != 0) begin
                    hppb_bvalid <= 1'b1;
                    hppb_bid <= b_q.pop_front();
                end else begin
                    hppb_bvalid <= 1'b0;
                end
            end
        end
    end

    // every step of the done counter must close a fully acknowledged batch
    always @(posedge axi4_mm_clk) begin
        if (!rst && mig_done_cnt != last_cnt) begin
            assert (mig_done_cnt == last_cnt + 64'd1)
                else stop_with_failure($sformatf("[FAIL] %0t: done count jumped from %0d to %0d",
                                                 $time, last_cnt, mig_done_cnt));
            assert (b_count == exp_lines && wr_count == exp_lines)
                else stop_with_failure($sformatf("[FAIL] %0t: batch counted at %0d of %0d responses",
                                                 $time, b_count, exp_lines));
        end
        last_cnt <= mig_done_cnt;
    end

    assert property (@(posedge axi4_mm_clk) disable iff (rst) hppb_arvalid && !hppb_arready
                     |=> hppb_arvalid && $stable(hppb_araddr) && $stable(hppb_arid))
        else stop_with_failure($sformatf("[FAIL] %0t: read request changed while stalled", $time));

    assert property (@(posedge axi4_mm_clk) disable iff (rst) hppb_awvalid && !hppb_awready
                     |=> hppb_awvalid && $stable(hppb_awaddr) && $stable(hppb_awid))
        else stop_with_failure($sformatf("[FAIL] %0t: write address changed while stalled", $time));

    assert property (@(posedge axi4_mm_clk) disable iff (rst) hppb_wvalid && !hppb_wready
                     |=> hppb_wvalid && $stable(hppb_wdata))
        else stop_with_failure($sformatf("[FAIL] %0t: write data changed while stalled", $time));

    task automatic check_reset_state();
        assert (!hppb_arvalid && !hppb_awvalid && !hppb_wvalid && !hot_page_push_inst.batch_done)
            else stop_with_failure($sformatf("[FAIL] %0t: a valid is high after reset", $time));
        assert (hppb_rready && mig_done_cnt == 64'd0 && !atleast_one_valid_src)
            else stop_with_failure($sformatf("[FAIL] %0t: rready %b count %0d after reset",
                                             $time, hppb_rready, mig_done_cnt));
    endtask

    // load one group, skip_page gets a zero source, then wait for its count
    task automatic run_batch(input int b, input int skip_page);
        addr_t s;
        addr_t d;
        int used_pages;
        logic [63:0] start_cnt;
        used_pages = 0;
        for (int p = 0; p < GRP; p++) begin
            s = 64'h0000_0001_0000_0000 + 64'(b) * 64'h0010_0000 + 64'(p) * 64'h1000;
            d = 64'h0000_0002_0040_0000 + 64'(b) * 64'h0010_0000 + 64'(p) * 64'h1000;
            if (p == skip_page) begin
                s = '0;
            end else begin
                used_pages++;
            end
            src_addr[p] <= s;
            dst_addr[p] <= d;
            src_tab[b][p] <= s;
            dst_tab[b][p] <= d;
        end
        start_cnt = mig_done_cnt;
        cur_batch <= b;
        exp_lines <= exp_lines + used_pages * PG_LINES;
        new_addr_available <= 1'b1;
        @(posedge axi4_mm_clk);
        new_addr_available <= 1'b0;
        @(posedge axi4_mm_clk);
        assert (atleast_one_valid_src)
            else stop_with_failure($sformatf("[FAIL] %0t: no valid source after load", $time));
        while (mig_done_cnt == start_cnt) begin
            @(posedge axi4_mm_clk);
        end
        assert (!atleast_one_valid_src)
            else stop_with_failure($sformatf("[FAIL] %0t: valid source left after done", $time));
        repeat (20) @(posedge axi4_mm_clk);
    endtask

    initial begin
        rst = 1'b1;
        new_addr_available = 1'b0;
        csr_aruser = 6'h0a;
        csr_awuser = 6'h15;
        for (int p = 0; p < GRP; p++) begin
            src_addr[p] = '0;
            dst_addr[p] = '0;
        end
        cur_batch = 0;
        exp_lines = 0;
        repeat (10) @(posedge axi4_mm_clk);
        rst <= 1'b0;
        @(posedge axi4_mm_clk);
        check_reset_state();
        run_batch(0, -1);
        run_batch(1, -1);
        run_batch(2, 1);    // page 1 has no source
        run_batch(3, -1);
        repeat (50) @(posedge axi4_mm_clk);
        if (mig_done_cnt == 64'(NUM_BATCHES) && rd_count == exp_lines && b_count == exp_lines) begin
            $display("TB PASSED");
            $finish;
        end else begin
            stop_with_failure($sformatf("[FAIL] %0t: %0d batches, %0d reads, %0d of %0d responses",
                                        $time, mig_done_cnt, rd_count, b_count, exp_lines));
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge axi4_mm_clk);
        stop_with_failure($sformatf("timeout: the batches did not finish within %0d cycles",
                                    TIMEOUT_CYCLES));
    end

endmodule

//--- project.f
source/page_migrate_pkg.sv
source/page_slot.sv
source/read_issuer.sv
source/line_fifo.sv
source/write_issuer.sv
source/batch_tracker.sv
source/hot_page_push.sv
test/tb_hot_page_push.sv

//--- Makefile
# Verilator flow for the hot page pusher

LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f project.f --top-module hot_page_push

sim:
	verilator --binary --timing --assert -f project.f --top-module tb_hot_page_push \
		-Mdir obj_dir -o sim_hot_page_push
	./obj_dir/sim_hot_page_push > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
